// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
TOP       = tb_mic_array
FILELIST  = all.f
OBJ_DIR   = obj_dir
PASS_MSG  = all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
hw/mic_pkg.sv
hw/i2s_rx.sv
hw/frame_capture.sv
hw/seg_scan.sv
hw/mic_array_top.sv
bench/mic_array_sva.sv
bench/tb_mic_array.sv

// ==== bench/mic_array_sva.sv ====
`timescale 1ns/100ps

module mic_array_sva (
    input logic audio_clk,
    input logic rst,
    input logic bclk,
    input logic lrcl,
    input logic frame_valid
);

    logic [$clog2(mic_pkg::BCLK_HALF):0] run_q;  // cycles bclk has held its level
    logic                                bclk_q;

    always_ff @(posedge audio_clk) begin
        if (rst) begin
            run_q  <= '0;
            bclk_q <= 1'b0;
        end else begin
            bclk_q <= bclk;
            if (bclk != bclk_q) begin
                run_q <= 1;
            end else begin
                run_q <= run_q + 1;
            end
        end
    end

    lrcl_on_bclk_fall: assert property (@(posedge audio_clk) disable iff (rst)
        $changed(lrcl) |-> $fell(bclk))
        else $error("lrcl changed outside a bclk falling edge");

    valid_single_cycle: assert property (@(posedge audio_clk) disable iff (rst)
        frame_valid |=> !frame_valid)
        else $error("frame_valid high for two cycles in a row");

    bclk_half_period: assert property (@(posedge audio_clk) disable iff (rst)
        $changed(bclk) |-> run_q == mic_pkg::BCLK_HALF)
        else $error("bclk level held for %0d cycles", run_q);

endmodule

bind i2s_rx mic_array_sva rx_checks (
    .audio_clk   (audio_clk),
    .rst         (rst),
    .bclk        (bclk),
    .lrcl        (lrcl),
    .frame_valid (frame_valid)
);

// ==== bench/tb_mic_array.sv ====
`timescale 1ns/100ps

module tb_mic_array;

    localparam int CLK_HALF_NS  = 10;
    localparam int FRAME_CYCLES = mic_pkg::FRAME_BITS * 2 * mic_pkg::BCLK_HALF;
    localparam int VALID_LIMIT  = 3 * FRAME_CYCLES; // startup drops two frames
    // frames per test: reset 3, capture 6, independence 2, freeze 4, scan 10
    localparam int TEST_FRAMES  = 3 + 6 + 2 + 4 + 10;
    localparam int WATCHDOG_NS  = TEST_FRAMES * FRAME_CYCLES * 2 * CLK_HALF_NS * 3 / 2;

    logic                         audio_clk = 1'b0;
    logic                         rst;
    logic [mic_pkg::NUM_MICS-1:0] mic_data = '0;
    mic_pkg::mic_sel_t            mic_sel;
    logic                         slot_right;
    logic                         update;
    logic [mic_pkg::NUM_MICS-1:0] mic_bclk;
    logic [mic_pkg::NUM_MICS-1:0] mic_lrcl;
    logic [mic_pkg::NUM_MICS-1:0] frame_valid;
    mic_pkg::i2s_slot_t           shown;
    mic_pkg::seg_drive_t          seg;

    // microphone models
    logic [63:0]                  tx_q0 [$];
    logic [63:0]                  tx_q1 [$];
    logic [63:0]                  tx_q2 [$];
    logic [63:0]                  cur_frame [3];
    int                           bit_cnt [3];
    logic [mic_pkg::NUM_MICS-1:0] bclk_seen;
    logic [mic_pkg::NUM_MICS-1:0] lrcl_seen;

    logic [63:0] sent [3] = '{default: '0}; // last frame queued per mic
    logic [15:0] lfsr_state = 16'd57;
    int          checks = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_run = 0;

    always #CLK_HALF_NS audio_clk = ~audio_clk;

    mic_array_top dut (
        .audio_clk   (audio_clk),
        .rst         (rst),
        .mic_data    (mic_data),
        .mic_sel     (mic_sel),
        .slot_right  (slot_right),
        .update      (update),
        .mic_bclk    (mic_bclk),
        .mic_lrcl    (mic_lrcl),
        .frame_valid (frame_valid),
        .shown       (shown),
        .seg         (seg)
    );

    function automatic logic [63:0] pop_frame(input int mic);
        logic [63:0] f;
        f = '0; // idle mic sends silence
        case (mic)
            0: if (tx_q0.size() > 0) f = tx_q0.pop_front();
            1: if (tx_q1.size() > 0) f = tx_q1.pop_front();
            default: if (tx_q2.size() > 0) f = tx_q2.pop_front();
        endcase
        return f;
    endfunction

    // each mic follows its own bclk/lrcl, drives data after the falling edge
    always @(posedge audio_clk) begin
        int          k;
        logic [63:0] nxt;
        for (int i = 0; i < mic_pkg::NUM_MICS; i++) begin
            if (rst) begin
                bclk_seen[i] <= 1'b0;
                lrcl_seen[i] <= 1'b0;
                bit_cnt[i]   <= 0;
                cur_frame[i] <= '0;
                mic_data[i]  <= 1'b0;
            end else begin
                bclk_seen[i] <= mic_bclk[i];
                lrcl_seen[i] <= mic_lrcl[i];
                if (bclk_seen[i] && !mic_bclk[i]) begin
                    // lrcl falling marks count 0
                    k = (lrcl_seen[i] && !mic_lrcl[i]) ? 0 : (bit_cnt[i] + 1) % 64;
                    bit_cnt[i] <= k;
                    if (k == 1) begin
                        nxt = pop_frame(i);
                        cur_frame[i] <= nxt;
                        mic_data[i]  <= nxt[63];
                    end else begin
                        mic_data[i] <= cur_frame[i][63 - ((k + 63) % 64)]; // one-bit delay
                    end
                end
            end
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hb400 : 16'h0000);
    endfunction

    function automatic logic [23:0] random_sample();
        logic [23:0] v;
        v = '0;
        for (int b = 0; b < 24; b++) begin
            lfsr_state = lfsr_next(lfsr_state); // one step per bit
            v = {v[22:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [63:0] random_frame();
        logic [23:0] left;
        logic [23:0] right;
        left  = random_sample();
        right = random_sample();
        return {left, 8'h00, right, 8'h00}; // pad bits are zero on a real mic
    endfunction

    // active-low segments from the lit letters of each hex shape
    function automatic logic [6:0] segments_for(input logic [3:0] hex);
        string      shape;
        logic [6:0] lit;
        case (hex)
            4'h0: shape = "abcdef";
            4'h1: shape = "bc";
            4'h2: shape = "abdeg";
            4'h3: shape = "abcdg";
            4'h4: shape = "bcfg";
            4'h5: shape = "acdfg";
            4'h6: shape = "acdefg";
            4'h7: shape = "abc";
            4'h8: shape = "abcdefg";
            4'h9: shape = "abcdfg";
            4'ha: shape = "abcefg";
            4'hb: shape = "cdefg";
            4'hc: shape = "adef";
            4'hd: shape = "bcdeg";
            4'he: shape = "adefg";
            default: shape = "aefg";
        endcase
        lit = '0;
        for (int j = 0; j < shape.len(); j++) begin
            lit[int'(shape[j]) - 97] = 1'b1; // 97 is 'a'
        end
        return ~lit;
    endfunction

    task automatic count_error();
        errors++;
        test_errors++;
    endtask

    task automatic check_slot(input string name, input mic_pkg::i2s_slot_t got,
                              input mic_pkg::i2s_slot_t exp);
        checks++;
        if (got !== exp) begin
            count_error();
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_seg(input string name, input mic_pkg::seg_drive_t got,
                             input mic_pkg::seg_drive_t exp);
        checks++;
        if (got !== exp) begin
            count_error();
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            count_error();
            $display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic wait_valid();
        int n;
        n = 0;
        do begin
            @(posedge audio_clk);
            n++;
        end while (!frame_valid[0] && n < VALID_LIMIT);
        if (!frame_valid[0]) begin
            count_error();
            $display("no frame_valid within %0d cycles at %0t ns", VALID_LIMIT, $time);
        end
    endtask

    task automatic queue_frame(input int mic, input logic [63:0] f);
        case (mic)
            0: tx_q0.push_back(f);
            1: tx_q1.push_back(f);
            default: tx_q2.push_back(f);
        endcase
        sent[mic] = f;
    endtask

    // align to a frame end so the frames go out in the next lrcl period
    task automatic send_frames(input logic [63:0] f0, input logic [63:0] f1,
                               input logic [63:0] f2);
        wait_valid();
        queue_frame(0, f0);
        queue_frame(1, f1);
        queue_frame(2, f2);
        wait_valid();
        check_bit("frame_valid[1]", frame_valid[1], 1'b1); // receivers in phase
        check_bit("frame_valid[2]", frame_valid[2], 1'b1);
        @(posedge audio_clk); // shown has taken the bypassed slot
    endtask

    task automatic select_and_check(input int mic, input logic right);
        mic_pkg::i2s_slot_t exp;
        exp = right ? sent[mic][31:0] : sent[mic][63:32];
        @(posedge audio_clk);
        mic_sel    <= mic_pkg::mic_sel_t'(mic);
        slot_right <= right;
        repeat (2) @(posedge audio_clk);
        check_slot("shown", shown, exp);
    endtask

    task automatic check_reset_outputs();
        for (int m = 0; m < mic_pkg::NUM_MICS; m++) begin
            check_bit("mic_bclk", mic_bclk[m], 1'b0);
            check_bit("mic_lrcl", mic_lrcl[m], 1'b0);
            check_bit("frame_valid", frame_valid[m], 1'b0);
        end
        check_slot("shown", shown, '0);
        check_bit("seg.an all high", seg.an == 8'hff, 1'b1);
    endtask

    task automatic test_reset_state();
        time released;
        repeat (3) @(posedge audio_clk);
        check_reset_outputs(); // still in reset
        @(posedge audio_clk);
        rst <= 1'b0;
        released = $time;
        @(posedge audio_clk); // state left by the last reset edge
        check_reset_outputs();
        wait_valid();
        check_bit("first frame_valid after two frames",
                  ($time - released) / (2 * CLK_HALF_NS) >= 2 * FRAME_CYCLES, 1'b1);
        finish_test("reset state");
    endtask

    task automatic test_frame_capture();
        logic [63:0] f;
        @(posedge audio_clk);
        update <= 1'b1;
        for (int m = 0; m < mic_pkg::NUM_MICS; m++) begin
            f = random_frame();
            send_frames(m == 0 ? f : '0, m == 1 ? f : '0, m == 2 ? f : '0);
            for (int s = 0; s < mic_pkg::NUM_MICS; s++) begin
                select_and_check(s, 1'b0);
                select_and_check(s, 1'b1);
            end
        end
        finish_test("frame capture");
    endtask

    task automatic test_independence();
        send_frames(random_frame(), random_frame(), random_frame());
        for (int s = 0; s < mic_pkg::NUM_MICS; s++) begin
            select_and_check(s, 1'b0);
            select_and_check(s, 1'b1);
        end
        finish_test("independence");
    endtask

    task automatic test_freeze();
        mic_pkg::i2s_slot_t frozen;
        @(posedge audio_clk);
        update     <= 1'b1;
        mic_sel    <= 2'd2;
        slot_right <= 1'b1;
        send_frames(random_frame(), random_frame(), random_frame());
        frozen = sent[2][31:0];
        check_slot("shown", shown, frozen);
        @(posedge audio_clk);
        update <= 1'b0;
        send_frames(random_frame(), random_frame(), random_frame());
        check_slot("shown", shown, frozen);
        @(posedge audio_clk);
        mic_sel    <= 2'd0; // selection moves, value must not
        slot_right <= 1'b0;
        repeat (2) @(posedge audio_clk);
        check_slot("shown", shown, frozen);
        @(posedge audio_clk);
        update     <= 1'b1;
        mic_sel    <= 2'd2;
        slot_right <= 1'b1;
        repeat (2) @(posedge audio_clk);
        check_slot("shown", shown, sent[2][31:0]);
        finish_test("freeze");
    endtask

    task automatic test_display_scan();
        logic [63:0]         frame;
        logic [31:0]         value;
        logic [7:0]          seen;
        mic_pkg::seg_drive_t exp;
        int                  n;
        logic                bad_an;
        frame = {24'h8b6fa2, 8'h00, 24'h3c91d4, 8'h00};
        value = frame[63:32];
        @(posedge audio_clk);
        mic_sel    <= 2'd0;
        slot_right <= 1'b0;
        send_frames(frame, '0, '0);
        check_slot("shown", shown, value);
        @(posedge audio_clk);
        update <= 1'b0; // hold it for the whole scan
        seen   = '0;
        bad_an = 1'b0;
        n      = 0;
        while (seen != 8'hff && n < 2 * 8 * mic_pkg::SCAN_DIV) begin
            @(posedge audio_clk);
            n++;
            if (!$onehot(~seg.an)) begin
                if (!bad_an) begin
                    count_error();
                    $display("anodes %b at %0t ns do not light exactly one digit",
                             seg.an, $time);
                end
                bad_an = 1'b1;
            end else begin
                for (int d = 0; d < 8; d++) begin
                    if (!seg.an[d] && !seen[d]) begin
                        exp.cat = segments_for(value[4 * d +: 4]);
                        exp.an  = ~(8'b1 << d);
                        check_seg("seg", seg, exp);
                        seen[d] = 1'b1;
                    end
                end
            end
        end
        if (seen != 8'hff) begin
            count_error();
            $display("only digits %b were lit during the scan", seen);
        end
        finish_test("display scan");
    endtask

    initial begin
        rst        <= 1'b1;
        mic_sel    <= '0;
        slot_right <= 1'b0;
        update     <= 1'b1;
        test_reset_state();
        test_frame_capture();
        test_independence();
        test_freeze();
        test_display_scan();
        $display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("run timed out after %0d ns before the tests finished", WATCHDOG_NS);
        $display("tests failed");
        $finish;
    end

endmodule

// ==== hw/frame_capture.sv ====
`timescale 1ns/100ps

module frame_capture (
    input  logic                                        audio_clk,
    input  logic                                        rst,
    input  logic [mic_pkg::NUM_MICS-1:0]                frame_valid,
    input  mic_pkg::i2s_frame_u [mic_pkg::NUM_MICS-1:0] frames,
    input  mic_pkg::mic_sel_t                           mic_sel,
    input  logic                                        slot_right,
    input  logic                                        update,
    output mic_pkg::i2s_slot_t                          shown
);

    mic_pkg::i2s_frame_u [mic_pkg::NUM_MICS-1:0] held_q; // latest frame per mic
    mic_pkg::mic_sel_t                           idx;
    mic_pkg::i2s_frame_u                         src;
    mic_pkg::i2s_slot_t                          pick;

    // take every frame, receivers do not wait
    always_ff @(posedge audio_clk) begin
        if (rst) begin
            held_q <= '0;
        end else begin
            for (int i = 0; i < mic_pkg::NUM_MICS; i++) begin
                if (frame_valid[i]) begin
                    held_q[i].raw <= frames[i].raw;
                end
            end
        end
    end

    // unused select code falls back to mic 0
    assign idx = (mic_sel < mic_pkg::mic_sel_t'(mic_pkg::NUM_MICS)) ? mic_sel : '0;

    always_comb begin
        src = held_q[idx];
        // bypass so a new frame reaches shown one cycle after its valid
        if (frame_valid[idx]) begin
            src = frames[idx];
        end
    end

    assign pick = slot_right ? src.slots.right : src.slots.left;

    // shown tracks the selection only while update is held
    always_ff @(posedge audio_clk) begin
        if (rst) begin
            shown <= '0;
        end else if (update) begin
            shown <= pick;
        end
    end

endmodule

// ==== hw/i2s_rx.sv ====
`timescale 1ns/100ps

module i2s_rx (
    input  logic                audio_clk,
    input  logic                rst,
    input  logic                mic_data,
    output logic                bclk,
    output logic                lrcl,
    output logic                frame_valid,
    output mic_pkg::i2s_frame_u frame
);

    typedef logic [$clog2(mic_pkg::BCLK_HALF)-1:0]  div_t;
    typedef logic [$clog2(mic_pkg::FRAME_BITS)-1:0] bit_t;

    div_t                           div_q;   // audio_clk cycles into this bclk half
    bit_t                           bit_q;   // bit position within the frame
    logic                           bclk_q;
    logic [mic_pkg::FRAME_BITS-1:0] shift_q; // deserializer, msb arrives first
    logic [1:0]                     warm_q;  // frame ends seen since reset
    logic                           half_done;
    logic                           rise;
    logic                           fall;
    logic                           frame_end;

    assign half_done = (div_q == div_t'(mic_pkg::BCLK_HALF - 1));
    assign rise      = half_done && !bclk_q; // bclk goes high at this edge
    assign fall      = half_done && bclk_q;

    // the one-bit I2S delay puts the last bit of a frame at count 0
    assign frame_end = rise && (bit_q == '0);

    assign bclk = bclk_q;
    assign lrcl = bit_q[$bits(bit_t)-1]; // low for the left half, high for the right

    // bit clock divider and bit counter
    always_ff @(posedge audio_clk) begin
        if (rst) begin
            div_q  <= '0;
            bclk_q <= 1'b0;
            bit_q  <= '0;
        end else begin
            if (half_done) begin
                div_q  <= '0;
                bclk_q <= !bclk_q;
            end else begin
                div_q <= div_q + 1'b1;
            end

            // count moves on the falling edge so lrcl and data change together
            if (fall) begin
                bit_q <= bit_q + 1'b1; // wraps 63 -> 0
            end
        end
    end

    // sample on the rising edge, mic drives on the falling one
    always_ff @(posedge audio_clk) begin
        if (rise) begin
            shift_q <= {shift_q[mic_pkg::FRAME_BITS-2:0], mic_data};
        end
    end

    // valid once per frame, after the warm-up frames are dropped
    always_ff @(posedge audio_clk) begin
        if (rst) begin
            warm_q      <= '0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= frame_end && (warm_q == 2'd2);

            // first end only closes a stub, second closes the startup frame
            if (frame_end && warm_q != 2'd2) begin
                warm_q <= warm_q + 1'b1;
            end
        end
    end

    // shift_q stays put for a whole bclk period after frame_end
    assign frame.raw = shift_q;

endmodule

// ==== hw/mic_array_top.sv ====
`timescale 1ns/100ps

module mic_array_top (
    input  logic                         audio_clk,
    input  logic                         rst,
    input  logic [mic_pkg::NUM_MICS-1:0] mic_data,
    input  mic_pkg::mic_sel_t            mic_sel,
    input  logic                         slot_right,
    input  logic                         update,
    output logic [mic_pkg::NUM_MICS-1:0] mic_bclk,
    output logic [mic_pkg::NUM_MICS-1:0] mic_lrcl,
    output logic [mic_pkg::NUM_MICS-1:0] frame_valid,
    output mic_pkg::i2s_slot_t           shown,
    output mic_pkg::seg_drive_t          seg
);

    mic_pkg::i2s_frame_u [mic_pkg::NUM_MICS-1:0] frames; // one per receiver

    // identical reset, so the three bit clocks stay in phase
    i2s_rx mic_rx_0 (
        .audio_clk   (audio_clk),
        .rst         (rst),
        .mic_data    (mic_data[0]),
        .bclk        (mic_bclk[0]),
        .lrcl        (mic_lrcl[0]),
        .frame_valid (frame_valid[0]),
        .frame       (frames[0])
    );

    i2s_rx mic_rx_1 (
        .audio_clk   (audio_clk),
        .rst         (rst),
        .mic_data    (mic_data[1]),
        .bclk        (mic_bclk[1]),
        .lrcl        (mic_lrcl[1]),
        .frame_valid (frame_valid[1]),
        .frame       (frames[1])
    );

    i2s_rx mic_rx_2 (
        .audio_clk   (audio_clk),
        .rst         (rst),
        .mic_data    (mic_data[2]),
        .bclk        (mic_bclk[2]),
        .lrcl        (mic_lrcl[2]),
        .frame_valid (frame_valid[2]),
        .frame       (frames[2])
    );

    frame_capture capture (
        .audio_clk   (audio_clk),
        .rst         (rst),
        .frame_valid (frame_valid),
        .frames      (frames),
        .mic_sel     (mic_sel),
        .slot_right  (slot_right),
        .update      (update),
        .shown       (shown)
    );

    // eight digits, the whole 32-bit slot in hex
    seg_scan display (
        .audio_clk   (audio_clk),
        .rst         (rst),
        .value       (shown),
        .seg         (seg)
    );

endmodule

// ==== hw/mic_pkg.sv ====
package mic_pkg;

    // board level counts
    localparam int NUM_MICS   = 3;
    localparam int FRAME_BITS = 64; // two 32-bit slots per lrcl period
    localparam int SLOT_BITS  = 32;

    // clocking, in audio_clk cycles (audio_clk is about 98.3 MHz)
    localparam int BCLK_HALF  = 16;   // bclk near 3.07 MHz
    localparam int SCAN_DIV   = 1024; // time each display digit stays lit

    // microphone index, 0 to NUM_MICS-1
    typedef logic [1:0] mic_sel_t;

    // one I2S slot as the MEMS mic sends it
    typedef struct packed {
        logic [23:0] sample; // msb first on the wire
        logic [7:0]  pad;    // trailing zero bits
    } i2s_slot_t;

    // left slot goes out while lrcl is low, so it lands in the upper half
    typedef struct packed {
        i2s_slot_t left;
        i2s_slot_t right;
    } i2s_slot_pair_t;

    // one full frame, latched as a word and picked apart by slot
    typedef union packed {
        logic [FRAME_BITS-1:0] raw;
        i2s_slot_pair_t        slots;
    } i2s_frame_u;

    // seven-segment drive, all active low
    typedef struct packed {
        logic [6:0] cat; // segments g down to a
        logic [7:0] an;  // digit enables, bit 0 is the rightmost digit
    } seg_drive_t;

endpackage

// ==== hw/seg_scan.sv ====
`timescale 1ns/100ps

module seg_scan (
    input  logic                audio_clk,
    input  logic                rst,
    input  mic_pkg::i2s_slot_t  value,
    output mic_pkg::seg_drive_t seg
);

    typedef logic [$clog2(mic_pkg::SCAN_DIV)-1:0]      scan_t;
    typedef logic [$clog2(mic_pkg::SLOT_BITS / 4)-1:0] digit_t;

    scan_t                         scan_q;  // prescaler
    digit_t                        digit_q; // digit being lit, 0 is rightmost
    logic [mic_pkg::SLOT_BITS-1:0] value_bits;
    logic [3:0]                    nibble;

    // hex digit to active-low segments, bit 6 is g and bit 0 is a
    function automatic logic [6:0] hex_to_seg(input logic [3:0] hex);
        logic [6:0] lit;
        case (hex)
            4'h0: lit = 7'h3f;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5b;
            4'h3: lit = 7'h4f;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6d;
            4'h6: lit = 7'h7d;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7f;
            4'h9: lit = 7'h6f;
            4'ha: lit = 7'h77;
            4'hb: lit = 7'h7c; // lower case b
            4'hc: lit = 7'h39;
            4'hd: lit = 7'h5e; // lower case d
            4'he: lit = 7'h79;
            default: lit = 7'h71; // F
        endcase
        return ~lit;
    endfunction

    // each digit stays on for SCAN_DIV cycles
    always_ff @(posedge audio_clk) begin
        if (rst) begin
            scan_q  <= '0;
            digit_q <= '0;
        end else if (scan_q == scan_t'(mic_pkg::SCAN_DIV - 1)) begin
            scan_q  <= '0;
            digit_q <= digit_q + 1'b1; // wraps after the leftmost digit
        end else begin
            scan_q <= scan_q + 1'b1;
        end
    end

    assign value_bits = value;
    assign nibble     = value_bits[4 * digit_q +: 4];

    // cathodes and anodes both registered, so they switch in the same cycle
    always_ff @(posedge audio_clk) begin
        if (rst) begin
            seg.cat <= '1;
            seg.an  <= '1; // all digits dark
        end else begin
            seg.cat <= hex_to_seg(nibble);
            seg.an  <= ~(8'b1 << digit_q); // one-cold
        end
    end

endmodule
